//--- flist.f
logic/apb_pkg.sv
logic/iob_pkg.sv
logic/apb2iob.sv
logic/iob_regfile.sv
logic/apb_iob_top.sv
testbench/tb_apb_iob_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the APB to IOb testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero when the testbench stops on $fatal.

TOP=tb_apb_iob_top
BUILD_DIR=obj_dir

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
   echo "Cannot enter the project directory"
   exit $status
fi

if ! command -v verilator > /dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert \
   -f flist.f \
   --top-module "$TOP" \
   -Mdir "$BUILD_DIR" \
   -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi

exit 0

//--- testbench/tb_apb_iob_top.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the APB to IOb register bank subsystem
// Applies a table of APB transfers and checks data and latency against a shadow model

module tb_apb_iob_top;

   localparam int          READY_TIMEOUT = 50;          // Cycles allowed per transfer
   localparam logic [31:0] LFSR_SEED     = 32'h0e2c_1e90;

   typedef struct packed {
      logic               write;
      apb_pkg::apb_addr_t addr;
      apb_pkg::apb_data_t data;
      apb_pkg::apb_strb_t strb;
      logic               rand_data;   // Data drawn from the LFSR when applied
      logic               check;
   } entry_t;

   logic               clk;
   logic               rst_n;
   logic               apb_sel;
   logic               apb_enable;
   logic               apb_write;
   apb_pkg::apb_addr_t apb_addr;
   apb_pkg::apb_data_t apb_wdata;
   apb_pkg::apb_strb_t apb_wstrb;
   logic               apb_ready;
   apb_pkg::apb_data_t apb_rdata;

   entry_t             stim_q [$];
   apb_pkg::apb_data_t shadow [iob_pkg::REG_NUM];   // Expected register contents
   logic [31:0]        lfsr_q;

   apb_iob_top i_apb_iob_top (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .apb_sel_i    (apb_sel),
      .apb_enable_i (apb_enable),
      .apb_write_i  (apb_write),
      .apb_addr_i   (apb_addr),
      .apb_wdata_i  (apb_wdata),
      .apb_wstrb_i  (apb_wstrb),
      .apb_ready_o  (apb_ready),
      .apb_rdata_o  (apb_rdata)
   );

   always #5 clk = ~clk;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic next_random(output apb_pkg::apb_data_t word);
      word = '0;
      for (int k = 0; k < apb_pkg::APB_DATA_W; k++) begin
         lfsr_q = lfsr_step(lfsr_q);
         word   = {word[apb_pkg::APB_DATA_W-2:0], lfsr_q[0]};   // One step per bit
      end
   endtask

   task automatic add_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data,
                            input apb_pkg::apb_strb_t strb, input logic rand_data);
      stim_q.push_back('{1'b1, addr, data, strb, rand_data, 1'b0});
   endtask

   task automatic add_read(input apb_pkg::apb_addr_t addr);
      stim_q.push_back('{1'b0, addr, '0, '0, 1'b0, 1'b1});
   endtask

   // Words live at addresses 0x00 to 0x3C, anything above reads zero
   function automatic apb_pkg::apb_data_t expected_read(input apb_pkg::apb_addr_t addr);
      if (addr[7:6] != 2'b00) begin
         return '0;
      end
      return shadow[addr[5:2]];
   endfunction

   task automatic update_shadow(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data,
                                input apb_pkg::apb_strb_t strb);
      if (addr[7:6] == 2'b00) begin
         for (int b = 0; b < apb_pkg::APB_STRB_W; b++) begin
            if (strb[b]) begin
               shadow[addr[5:2]][8*b +: 8] = data[8*b +: 8];
            end
         end
      end
   endtask

   task automatic check_data(input apb_pkg::apb_data_t got, input apb_pkg::apb_data_t exp,
                             input apb_pkg::apb_addr_t addr);
      if (got !== exp) begin
         $display("Fail at %0t: apb_rdata_o (addr %h) got %h expected %h", $time, addr, got, exp);
         $display("Test FAILED");
         $fatal(1, "read data mismatch");
      end
   endtask

   task automatic check_latency(input iob_pkg::wait_cnt_t w, input logic write, input int cycles);
      int exp;
      exp = write ? int'(w) + 2 : int'(w) + 3;
      if (cycles != exp) begin
         $display("Fail at %0t: apb_ready_o latency (W %0d) got %0d expected %0d",
                  $time, w, cycles, exp);
         $display("Test FAILED");
         $fatal(1, "transfer latency mismatch");
      end
   endtask

   task automatic check_ready(input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail at %0t: apb_ready_o got %b expected %b", $time, got, exp);
         $display("Test FAILED");
         $fatal(1, "ready pulse mismatch");
      end
   endtask

   // Setup phase, access phase, then wait for ready; idle cycle after
   task automatic apb_transfer(input logic write, input apb_pkg::apb_addr_t addr,
                               input apb_pkg::apb_data_t wdata, input apb_pkg::apb_strb_t strb,
                               output apb_pkg::apb_data_t rdata, output int cycles);
      int   waited;
      logic done;
      @(posedge clk);
      apb_sel    <= 1'b1;
      apb_enable <= 1'b0;
      apb_write  <= write;
      apb_addr   <= addr;
      apb_wdata  <= wdata;
      apb_wstrb  <= strb;
      @(posedge clk);
      apb_enable <= 1'b1;   // Next cycle is cycle 0 of the transfer
      waited = 0;
      done   = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (apb_ready) begin
            done = 1'b1;
         end else begin
            waited++;
            if (waited > READY_TIMEOUT) begin
               $display("Timeout at %0t: no apb_ready_o for transfer to address %h", $time, addr);
               $display("Test FAILED");
               $fatal(1, "APB transfer timed out");
            end
         end
      end
      rdata  = apb_rdata;
      cycles = waited;
      @(posedge clk);
      apb_sel    <= 1'b0;
      apb_enable <= 1'b0;
      @(negedge clk);
      check_ready(apb_ready, 1'b0);   // Single cycle pulse
   endtask

   initial begin
      entry_t             cur;
      apb_pkg::apb_data_t data;
      apb_pkg::apb_data_t rdata;
      iob_pkg::wait_cnt_t w_now;
      int                 cycles;

      clk        = 1'b0;
      rst_n      = 1'b0;
      apb_sel    = 1'b0;
      apb_enable = 1'b0;
      apb_write  = 1'b0;
      apb_addr   = '0;
      apb_wdata  = '0;
      apb_wstrb  = '0;
      lfsr_q     = LFSR_SEED;
      for (int i = 0; i < iob_pkg::REG_NUM; i++) begin
         shadow[i] = '0;
      end

      // Reads straight after reset
      add_read(8'h04);
      add_read(8'h20);
      add_read(8'h3C);
      add_read(8'h00);
      for (int i = 1; i < iob_pkg::REG_NUM; i++) begin
         add_write(apb_pkg::apb_addr_t'(i * 4), '0, 4'hF, 1'b1);
      end
      for (int i = 1; i < iob_pkg::REG_NUM; i++) begin
         add_read(apb_pkg::apb_addr_t'(i * 4));
      end
      // Partial byte lanes
      add_write(8'h0C, 32'h1122_3344, 4'b0101, 1'b0);
      add_read(8'h0C);
      add_write(8'h1C, 32'hA5A5_A5A5, 4'b1000, 1'b0);
      add_read(8'h1C);
      add_write(8'h30, 32'hDEAD_BEEF, 4'b0110, 1'b0);
      add_read(8'h30);
      // Wait states 3, 15, then back to 0 through the low bits only
      add_write(8'h00, 32'h0000_0003, 4'hF, 1'b0);
      add_read(8'h00);
      add_write(8'h08, '0, 4'hF, 1'b1);
      add_read(8'h08);
      add_write(8'h00, 32'h0000_000F, 4'hF, 1'b0);
      add_write(8'h10, '0, 4'hF, 1'b1);
      add_read(8'h10);
      add_write(8'h00, 32'hFFFF_FFF0, 4'hF, 1'b0);
      add_read(8'h00);
      add_write(8'h14, '0, 4'hF, 1'b1);
      add_read(8'h14);
      // Out of range, then every word again
      add_write(8'h40, '0, 4'hF, 1'b1);
      add_write(8'h84, '0, 4'hF, 1'b1);
      add_write(8'hFC, '0, 4'hF, 1'b1);
      add_read(8'h40);
      add_read(8'hC8);
      add_read(8'hFC);
      for (int i = 0; i < iob_pkg::REG_NUM; i++) begin
         add_read(apb_pkg::apb_addr_t'(i * 4));
      end

      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_ready(apb_ready, 1'b0);
      check_data(apb_rdata, '0, '0);

      foreach (stim_q[i]) begin
         cur   = stim_q[i];
         w_now = shadow[iob_pkg::WAIT_REG][iob_pkg::WAIT_W-1:0];   // W in force for this transfer
         if (cur.rand_data) begin
            next_random(data);
         end else begin
            data = cur.data;
         end
         apb_transfer(cur.write, cur.addr, data, cur.strb, rdata, cycles);
         check_latency(w_now, cur.write, cycles);
         if (cur.write) begin
            update_shadow(cur.addr, data, cur.strb);
         end else if (cur.check) begin
            check_data(rdata, expected_read(cur.addr), cur.addr);
         end
      end

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/apb_iob_top.sv
`timescale 1ns/1ps
`default_nettype none

// APB peripheral: bridge in front of the register bank

module apb_iob_top (
   input  wire                clk_i,
   input  wire                rst_n_i,

   input  wire                apb_sel_i,
   input  wire                apb_enable_i,
   input  wire                apb_write_i,
   input  wire apb_pkg::apb_addr_t apb_addr_i,
   input  wire apb_pkg::apb_data_t apb_wdata_i,
   input  wire apb_pkg::apb_strb_t apb_wstrb_i,
   output logic               apb_ready_o,
   output apb_pkg::apb_data_t apb_rdata_o
);

   // Internal IOb bus
   logic               iob_valid;
   iob_pkg::iob_addr_t iob_addr;
   iob_pkg::iob_data_t iob_wdata;
   iob_pkg::iob_strb_t iob_wstrb;
   logic               iob_ready;
   logic               iob_rvalid;
   iob_pkg::iob_data_t iob_rdata;

   apb2iob i_apb2iob (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .apb_sel_i    (apb_sel_i),
      .apb_enable_i (apb_enable_i),
      .apb_write_i  (apb_write_i),
      .apb_addr_i   (apb_addr_i),
      .apb_wdata_i  (apb_wdata_i),
      .apb_wstrb_i  (apb_wstrb_i),
      .apb_ready_o  (apb_ready_o),
      .apb_rdata_o  (apb_rdata_o),
      .iob_valid_o  (iob_valid),
      .iob_addr_o   (iob_addr),
      .iob_wdata_o  (iob_wdata),
      .iob_wstrb_o  (iob_wstrb),
      .iob_ready_i  (iob_ready),
      .iob_rvalid_i (iob_rvalid),
      .iob_rdata_i  (iob_rdata)
   );

   iob_regfile i_iob_regfile (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .iob_valid_i  (iob_valid),
      .iob_addr_i   (iob_addr),
      .iob_wdata_i  (iob_wdata),
      .iob_wstrb_i  (iob_wstrb),
      .iob_ready_o  (iob_ready),
      .iob_rvalid_o (iob_rvalid),
      .iob_rdata_o  (iob_rdata)
   );

endmodule

`default_nettype wire

//--- logic/iob_regfile.sv
`timescale 1ns/1ps
`default_nettype none

// IOb slave with sixteen 32-bit words
// Word 0 low bits set how many cycles ready is held back

module iob_regfile (
   input  wire                clk_i,
   input  wire                rst_n_i,

   input  wire                iob_valid_i,
   input  wire iob_pkg::iob_addr_t iob_addr_i,
   input  wire iob_pkg::iob_data_t iob_wdata_i,
   input  wire iob_pkg::iob_strb_t iob_wstrb_i,
   output logic               iob_ready_o,
   output logic               iob_rvalid_o,
   output iob_pkg::iob_data_t iob_rdata_o
);

   iob_pkg::iob_data_t regs_q [iob_pkg::REG_NUM];

   iob_pkg::reg_idx_t  reg_idx;
   logic               in_range;
   iob_pkg::wait_cnt_t wait_cfg;
   iob_pkg::wait_cnt_t wait_cnt_q;   // Cycles left before ready
   logic               pending_q;    // Valid seen, not yet accepted
   logic               new_req;
   logic               accept;
   logic               wr_accept;
   logic               rd_accept;

   assign reg_idx  = iob_addr_i[iob_pkg::REG_IDX_W+1:2];
   // Bits above the word index must be clear
   assign in_range = ~|iob_addr_i[iob_pkg::IOB_ADDR_W-1:iob_pkg::REG_IDX_W+2];
   assign wait_cfg = regs_q[iob_pkg::WAIT_REG][iob_pkg::WAIT_W-1:0];

   assign new_req   = iob_valid_i & ~pending_q;
   assign accept    = iob_valid_i & iob_ready_o;
   assign wr_accept = accept & (|iob_wstrb_i);
   assign rd_accept = accept & ~(|iob_wstrb_i);

   // A zero wait field answers in the first valid cycle
   always_comb begin
      if (!iob_valid_i) begin
         iob_ready_o = 1'b0;
      end else if (new_req) begin
         iob_ready_o = (wait_cfg == '0);
      end else begin
         iob_ready_o = (wait_cnt_q == '0);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pending_q  <= 1'b0;
         wait_cnt_q <= '0;
      end else begin
         pending_q <= iob_valid_i & ~iob_ready_o;
         if (new_req && wait_cfg != '0) begin
            wait_cnt_q <= wait_cfg - iob_pkg::wait_cnt_t'(1);   // First stall cycle already spent
         end else if (pending_q && iob_valid_i && wait_cnt_q != '0) begin
            wait_cnt_q <= wait_cnt_q - iob_pkg::wait_cnt_t'(1);
         end
      end
   end

   // Byte lane writes that skip out of range addresses
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < iob_pkg::REG_NUM; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_accept && in_range) begin
         for (int b = 0; b < iob_pkg::IOB_STRB_W; b++) begin
            if (iob_wstrb_i[b]) begin
               regs_q[reg_idx][8*b +: 8] <= iob_wdata_i[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         iob_rvalid_o <= 1'b0;
      end else begin
         iob_rvalid_o <= rd_accept;   // One cycle after the read accept
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_accept) begin
         iob_rdata_o <= in_range ? regs_q[reg_idx] : '0;
      end
   end

   // Read data strobe lasts a single cycle per read
   a_rvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_rvalid_o |=> !iob_rvalid_o)
      else $error("IOb rvalid high for more than one cycle");

endmodule

`default_nettype wire

//--- logic/apb2iob.sv
`timescale 1ns/1ps
`default_nettype none

// APB slave port driving an IOb master interface
// One transfer in flight at a time and ready answered with a one-cycle pulse

module apb2iob (
   input  wire                clk_i,
   input  wire                rst_n_i,

   // APB slave side
   input  wire                apb_sel_i,
   input  wire                apb_enable_i,
   input  wire                apb_write_i,
   input  wire apb_pkg::apb_addr_t apb_addr_i,
   input  wire apb_pkg::apb_data_t apb_wdata_i,
   input  wire apb_pkg::apb_strb_t apb_wstrb_i,
   output logic               apb_ready_o,
   output apb_pkg::apb_data_t apb_rdata_o,

   // IOb master side
   output logic               iob_valid_o,
   output iob_pkg::iob_addr_t iob_addr_o,
   output iob_pkg::iob_data_t iob_wdata_o,
   output iob_pkg::iob_strb_t iob_wstrb_o,
   input  wire                iob_ready_i,
   input  wire                iob_rvalid_i,
   input  wire iob_pkg::iob_data_t iob_rdata_i
);

   typedef enum logic [1:0] {
      IDLE,     // Waiting for sel and enable
      ACCESS,   // Valid held until ready
      RDATA,    // Read accepted, waiting for rvalid
      RESPOND   // Ready pulse towards APB
   } state_t;

   state_t state_q;
   state_t state_nxt;

   // Request fields come straight from the APB bus as the master holds them
   assign iob_valid_o = (state_q == ACCESS);
   assign iob_addr_o  = iob_pkg::iob_addr_t'(apb_addr_i);
   assign iob_wdata_o = iob_pkg::iob_data_t'(apb_wdata_i);
   assign iob_wstrb_o = apb_write_i ? iob_pkg::iob_strb_t'(apb_wstrb_i) : '0;   // Zero means read

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         IDLE: begin
            if (apb_sel_i && apb_enable_i) begin
               state_nxt = ACCESS;
            end
         end
         ACCESS: begin
            if (iob_ready_i) begin
               // Writes have no rvalid, so answer right away
               state_nxt = apb_write_i ? RESPOND : RDATA;
            end
         end
         RDATA: begin
            if (iob_rvalid_i) begin
               state_nxt = RESPOND;
            end
         end
         default: begin   // RESPOND
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_nxt;
      end
   end

   // Ready lines up with the RESPOND state
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         apb_ready_o <= 1'b0;
      end else begin
         apb_ready_o <= (state_nxt == RESPOND);
      end
   end

   // Read data held for the APB master until the next read
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         apb_rdata_o <= '0;
      end else if (state_q == RDATA && iob_rvalid_i) begin
         apb_rdata_o <= apb_pkg::apb_data_t'(iob_rdata_i);
      end
   end

   // Request must not change or vanish while the bank stalls
   a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_valid_o && !iob_ready_i |=> iob_valid_o && $stable(iob_addr_o))
      else $error("IOb valid or address changed before ready");

   // Ready only answers an access phase the master still holds
   a_ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb_ready_o |-> apb_sel_i && apb_enable_i)
      else $error("APB ready outside a selected access phase");

endmodule

`default_nettype wire

//--- logic/iob_pkg.sv
`default_nettype none

// Native IOb bus widths and the layout of the register bank behind it

package iob_pkg;

   localparam int IOB_ADDR_W = 8;      // Byte address
   localparam int IOB_DATA_W = 32;
   localparam int IOB_STRB_W = IOB_DATA_W / 8;

   typedef logic [IOB_ADDR_W-1:0] iob_addr_t;
   typedef logic [IOB_DATA_W-1:0] iob_data_t;
   typedef logic [IOB_STRB_W-1:0] iob_strb_t;   // All zero on a read

   // Register bank geometry
   localparam int REG_NUM   = 16;
   localparam int REG_IDX_W = 4;       // Word index, address bits 5 to 2

   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // Word 0 carries the wait-state count
   localparam reg_idx_t WAIT_REG = 4'd0;
   localparam int       WAIT_W   = 4;  // Low bits of word 0

   typedef logic [WAIT_W-1:0] wait_cnt_t;

endpackage

`default_nettype wire

//--- logic/apb_pkg.sv
`default_nettype none

// Widths and vector types seen on the APB slave port

package apb_pkg;

   // Byte address, enough for the whole register window
   localparam int APB_ADDR_W = 8;

   localparam int APB_DATA_W = 32;      // One word per transfer
   localparam int APB_STRB_W = APB_DATA_W / 8;   // Byte lanes

   // Address as driven by the APB master
   typedef logic [APB_ADDR_W-1:0] apb_addr_t;

   // Write and read data
   typedef logic [APB_DATA_W-1:0] apb_data_t;

   typedef logic [APB_STRB_W-1:0] apb_strb_t;   // Per lane write enables

endpackage

`default_nettype wire
